// ==== arbiter/desc_arbiter.sv ====
// blocking arbiter, round-robin or fixed priority, released by acknowledge
`timescale 1ns/100ps
`default_nettype none

module desc_arbiter import desc_mux_pkg::*; #(
    parameter int ports             = 4,
    parameter bit arb_round_robin   = 1'b1,
    parameter bit arb_lsb_high_prio = 1'b1
) (
    input  wire              clk,
    input  wire              rst,

    input  wire  [ports-1:0] req,
    input  wire  [ports-1:0] ack,
    output logic [ports-1:0] grant,
    output logic             grant_valid,
    output port_idx_t        grant_idx
);

    typedef enum logic {
        st_idle,
        st_granted
    } state_t;

    state_t           state;
    logic [ports-1:0] cand_req;
    logic [ports-1:0] pick_grant;
    logic             pick_found;
    port_idx_t        pick_idx;
    logic             ack_hit;
    int               cand;

    assign ack_hit = |(ack & grant);
    assign grant_valid = (state == st_granted);

    // acknowledged port steps aside for this pick
    assign cand_req = req & ~ack;

    always_comb begin
        pick_found = 1'b0;
        pick_idx = '0;
        cand = 0;
        for (int i = 0; i < ports; i++) begin
            if (arb_round_robin) begin
                // rotate from the last winner, grant_idx holds it
                if (arb_lsb_high_prio) begin
                    cand = int'(grant_idx) + 1 + i;
                end else begin
                    cand = int'(grant_idx) + ports - 1 - i;
                end
                if (cand >= ports) begin
                    cand = cand - ports;
                end
            end else begin
                cand = arb_lsb_high_prio ? i : ports - 1 - i;
            end
            if (!pick_found && cand_req[cand]) begin
                pick_found = 1'b1;
                pick_idx = port_idx_t'(cand);
            end
        end
    end

    always_comb begin
        for (int n = 0; n < ports; n++) begin
            pick_grant[n] = pick_found && (pick_idx == n);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            grant <= '0;
            grant_idx <= port_idx_t'(ports - 1);
        end else if (state == st_idle || ack_hit) begin
            if (pick_found) begin
                state <= st_granted;
                grant <= pick_grant;
                grant_idx <= pick_idx;
            end else begin
                state <= st_idle;
                grant <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant not one-hot");

endmodule

`default_nettype wire

// ==== bench/desc_mux_model.svh ====
// per-port expected descriptor queues, outstanding engine tags, widening and narrowing rules
`ifndef desc_mux_model_svh
`define desc_mux_model_svh

// accepted descriptors in acceptance order, already widened
dma_desc_t exp_q[4][$];
// tags the engine has received and may complete
dma_tag_t  tag_q[$];

// port number lands in select bits 5:4 and tag bits 9:8
function automatic dma_desc_t widen_desc(client_desc_t d, int port);
    dma_desc_t w;
    w.src_addr = d.src_addr;
    w.src_sel = dma_sel_t'(port * 16 + d.src_sel);
    w.dst_addr = d.dst_addr;
    w.dst_sel = dma_sel_t'(port * 16 + d.dst_sel);
    w.len = d.len;
    w.tag = dma_tag_t'(port * 256 + d.tag);
    return w;
endfunction

function automatic client_sts_t narrow_sts(dma_sts_t s);
    client_sts_t c;
    c.len = s.len;
    c.tag = s.tag[7:0];
    c.error = s.error;
    return c;
endfunction

function automatic int pending_count();
    int n;
    n = 0;
    for (int p = 0; p < 4; p++) begin
        n += exp_q[p].size();
    end
    return n;
endfunction

`endif

// ==== bench/desc_mux_tb.sv ====
// testbench for the descriptor mux with random traffic, engine back-pressure and a queue model
`timescale 1ns/100ps
`default_nettype none

module desc_mux_tb import desc_mux_pkg::*; ();

    logic               clk = 1'b0;
    logic               rst;
    client_desc_t [3:0] client_req_desc;
    logic [3:0]         client_req_valid;
    logic [3:0]         client_req_ready;
    dma_desc_t          dma_req_desc;
    logic               dma_req_valid;
    logic               dma_req_ready;
    dma_sts_t           dma_sts;
    logic               dma_sts_valid;
    client_sts_t        client_sts;
    logic [3:0]         client_sts_valid;

    logic [3:0]         took = '0;
    logic [3:0]         sts_want_valid = '0;
    client_sts_t        sts_want;
    bit                 fair_on = 1'b0;
    int                 last_port = -1;
    int                 errors = 0;
    int                 err_mark = 0;
    int                 checks = 0;
    int                 tests = 0;

    `include "desc_mux_model.svh"

    desc_mux #(.ports(4)) dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    task automatic show_mismatch(string sig, logic [127:0] want, logic [127:0] got);
        $display("mismatch at %0t: %s expected %h, got %h", $time, sig, want, got);
        errors++;
    endtask

    task automatic note_failure(string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(string name);
        $display("test %s done with %0d errors", name, errors - err_mark);
        err_mark = errors;
        tests++;
    endtask

    function automatic bit still_busy();
        return client_req_valid != '0 || dma_req_valid || pending_count() != 0;
    endfunction

    // clients hold an offer until it is taken, then maybe offer a new one
    task automatic drive_traffic(int cycles, bit rand_ready, bit all_full, bit with_sts);
        repeat (cycles) begin
            @(negedge clk);
            for (int p = 0; p < 4; p++) begin
                if (!client_req_valid[p] || took[p]) begin
                    client_req_valid[p] = all_full || ($urandom % 3 == 0);
                    client_req_desc[p] = {$urandom, $urandom, $urandom};
                end
            end
            dma_req_ready = rand_ready ? 1'($urandom) : 1'b1;
            dma_sts_valid = with_sts && tag_q.size() > 0 && ($urandom % 2 == 0);
            if (dma_sts_valid) begin
                dma_sts = {16'($urandom), tag_q.pop_front(), 4'($urandom)};
            end
        end
    endtask

    task automatic drain(int limit);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            client_req_valid = client_req_valid & ~took;
            dma_req_ready = 1'b1;
            dma_sts_valid = 1'b0;
            waited++;
        end while (still_busy() && waited < limit);
        if (still_busy()) begin
            note_failure("timeout, accepted descriptors never reached the engine");
        end
    endtask

    always @(posedge clk) begin : monitor
        int port;
        dma_desc_t want;
        if (!rst) begin
            // status comes out one edge after the strobe was sampled
            checks++;
            assert (client_sts_valid == sts_want_valid)
                else show_mismatch("client_sts_valid", sts_want_valid, client_sts_valid);
            if (sts_want_valid != '0) begin
                assert (client_sts == sts_want)
                    else show_mismatch("client_sts", sts_want, client_sts);
            end
            sts_want_valid = dma_sts_valid ? 4'b0001 << dma_sts.tag[9:8] : 4'b0000;
            sts_want = narrow_sts(dma_sts);

            if (dma_req_valid && dma_req_ready) begin
                port = int'(dma_req_desc.tag[9:8]);
                checks++;
                assert (exp_q[port].size() != 0)
                    else note_failure("engine got a descriptor that no client handed in");
                if (exp_q[port].size() != 0) begin
                    want = exp_q[port].pop_front();
                    assert (dma_req_desc == want)
                        else show_mismatch("dma_req_desc", want, dma_req_desc);
                end
                tag_q.push_back(dma_req_desc.tag);
                if (fair_on && last_port >= 0) begin
                    assert (port == (last_port + 1) % 4)
                        else show_mismatch("engine port order", (last_port + 1) % 4, port);
                end
                last_port = port;
            end

            for (int p = 0; p < 4; p++) begin
                took[p] = client_req_valid[p] && client_req_ready[p];
                if (took[p]) begin
                    exp_q[p].push_back(widen_desc(client_req_desc[p], p));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hd17b));
        rst = 1'b1;
        client_req_valid = '0;
        client_req_desc = '0;
        dma_req_ready = 1'b0;
        // status strobe held high through reset must not reach any client
        dma_sts = {16'($urandom), 10'($urandom), 4'($urandom)};
        dma_sts_valid = 1'b1;
        repeat (10) begin
            @(negedge clk);
            checks++;
            assert (!dma_req_valid && client_sts_valid == '0)
                else note_failure("engine request or client status valid during reset");
        end
        rst = 1'b0;
        dma_sts_valid = 1'b0;
        @(negedge clk);
        checks++;
        assert (!dma_req_valid && client_sts_valid == '0 && client_req_ready == 4'hf)
            else note_failure("outputs not idle on the first cycle after reset");
        finish_test("reset");

        drive_traffic(300, 1'b0, 1'b0, 1'b0);
        drain(200);
        finish_test("widening");

        drive_traffic(400, 1'b1, 1'b0, 1'b0);
        drain(200);
        finish_test("backpressure");

        // all ports stay full, engine always ready
        last_port = -1;
        fair_on = 1'b1;
        drive_traffic(120, 1'b0, 1'b1, 1'b0);
        drain(200);
        fair_on = 1'b0;
        finish_test("fairness");

        drive_traffic(300, 1'b1, 1'b0, 1'b1);
        drain(200);
        finish_test("status");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
common/desc_mux_pkg.sv
hw/desc_hold_reg.sv
arbiter/desc_arbiter.sv
hw/desc_skid_buffer.sv
hw/desc_sts_demux.sv
hw/desc_mux.sv
bench/desc_mux_tb.sv

// ==== common/desc_mux_pkg.sv ====
// widths, vector typedefs and descriptor and status structs for the descriptor mux
`default_nettype none

package desc_mux_pkg;

    // port index bits carried in the top of tag and select fields
    localparam int port_idx_w = 2;

    typedef logic [31:0] addr_t;
    typedef logic [15:0] len_t;

    typedef logic [7:0] client_tag_t;
    typedef logic [port_idx_w+7:0] dma_tag_t;

    typedef logic [3:0] client_sel_t;
    typedef logic [port_idx_w+3:0] dma_sel_t;

    typedef logic [port_idx_w-1:0] port_idx_t;
    typedef logic [3:0] sts_error_t;

    typedef struct packed {
        addr_t       src_addr;
        client_sel_t src_sel;
        addr_t       dst_addr;
        client_sel_t dst_sel;
        len_t        len;
        client_tag_t tag;
    } client_desc_t;

    // engine side, selects and tag widened by the port index
    typedef struct packed {
        addr_t    src_addr;
        dma_sel_t src_sel;
        addr_t    dst_addr;
        dma_sel_t dst_sel;
        len_t     len;
        dma_tag_t tag;
    } dma_desc_t;

    typedef struct packed {
        len_t       len;
        dma_tag_t   tag;
        sts_error_t error;
    } dma_sts_t;

    typedef struct packed {
        len_t        len;
        client_tag_t tag;
        sts_error_t  error;
    } client_sts_t;

endpackage

`default_nettype wire

// ==== hw/desc_hold_reg.sv ====
// single-entry holding register for one client request port
`timescale 1ns/100ps
`default_nettype none

module desc_hold_reg import desc_mux_pkg::*; (
    input  wire          clk,
    input  wire          rst,

    input  client_desc_t in_desc,
    input  wire          in_valid,
    output logic         in_ready,

    input  wire          take,
    output client_desc_t held_desc,
    output logic         held
);

    // free now, or freed by the take in this same cycle
    assign in_ready = !held || take;

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held_desc <= in_desc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (in_valid && in_ready) begin
            held <= 1'b1;
        end else if (take) begin
            held <= 1'b0;
        end
    end

    // the mux may only take a descriptor that was loaded earlier
    assert property (@(posedge clk) disable iff (rst) take |-> held)
        else $error("take on empty holding register");

endmodule

`default_nettype wire

// ==== hw/desc_mux.sv ====
// descriptor mux top level: holding registers, arbiter, widening, skid buffer, status router
`timescale 1ns/100ps
`default_nettype none

module desc_mux import desc_mux_pkg::*; #(
    parameter int ports             = 4,
    parameter bit arb_round_robin   = 1'b1,
    parameter bit arb_lsb_high_prio = 1'b1
) (
    input  wire                          clk,
    input  wire                          rst,

    input  client_desc_t [ports-1:0]     client_req_desc,
    input  wire          [ports-1:0]     client_req_valid,
    output logic         [ports-1:0]     client_req_ready,

    output dma_desc_t                    dma_req_desc,
    output logic                         dma_req_valid,
    input  wire                          dma_req_ready,

    input  dma_sts_t                     dma_sts,
    input  wire                          dma_sts_valid,
    output client_sts_t                  client_sts,
    output logic         [ports-1:0]     client_sts_valid
);

    if (ports < 2 || ports > 4) begin : g_ports_check
        $fatal(1, "ports must be 2 to 4, got %0d", ports);
    end

    client_desc_t [ports-1:0] held_desc;
    logic [ports-1:0]         held;
    logic [ports-1:0]         take;
    logic [ports-1:0]         grant;
    logic                     grant_valid;
    port_idx_t                grant_idx;
    client_desc_t             sel_desc;
    dma_desc_t                wide_desc;
    logic                     wide_valid;
    logic                     wide_ready;

    for (genvar n = 0; n < ports; n++) begin : g_port
        desc_hold_reg hold_inst (
            .clk       (clk),
            .rst       (rst),
            .in_desc   (client_req_desc[n]),
            .in_valid  (client_req_valid[n]),
            .in_ready  (client_req_ready[n]),
            .take      (take[n]),
            .held_desc (held_desc[n]),
            .held      (held[n])
        );
    end

    desc_arbiter #(
        .ports             (ports),
        .arb_round_robin   (arb_round_robin),
        .arb_lsb_high_prio (arb_lsb_high_prio)
    ) arb_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (held),
        .ack         (take),
        .grant       (grant),
        .grant_valid (grant_valid),
        .grant_idx   (grant_idx)
    );

    assign take = grant & held & {ports{wide_ready}};
    assign wide_valid = grant_valid && |(grant & held);

    // port index goes into the top bits of tag and both selects
    always_comb begin
        sel_desc = held_desc[grant_idx];
        wide_desc.src_addr = sel_desc.src_addr;
        wide_desc.src_sel = {grant_idx, sel_desc.src_sel};
        wide_desc.dst_addr = sel_desc.dst_addr;
        wide_desc.dst_sel = {grant_idx, sel_desc.dst_sel};
        wide_desc.len = sel_desc.len;
        wide_desc.tag = {grant_idx, sel_desc.tag};
    end

    desc_skid_buffer skid_inst (
        .clk       (clk),
        .rst       (rst),
        .in_desc   (wide_desc),
        .in_valid  (wide_valid),
        .in_ready  (wide_ready),
        .out_desc  (dma_req_desc),
        .out_valid (dma_req_valid),
        .out_ready (dma_req_ready)
    );

    desc_sts_demux #(
        .ports (ports)
    ) sts_inst (
        .clk       (clk),
        .rst       (rst),
        .in_sts    (dma_sts),
        .in_valid  (dma_sts_valid),
        .out_sts   (client_sts),
        .out_valid (client_sts_valid)
    );

endmodule

`default_nettype wire

// ==== hw/desc_skid_buffer.sv ====
// output register plus temp register, registered ready towards the arbitration side
`timescale 1ns/100ps
`default_nettype none

module desc_skid_buffer import desc_mux_pkg::*; (
    input  wire       clk,
    input  wire       rst,

    input  dma_desc_t in_desc,
    input  wire       in_valid,
    output logic      in_ready,

    output dma_desc_t out_desc,
    output logic      out_valid,
    input  wire       out_ready
);

    dma_desc_t temp_desc;
    logic      temp_valid;
    logic      out_valid_next;
    logic      temp_valid_next;
    logic      in_xfer;
    logic      in_ready_early;
    logic      store_in_to_out;
    logic      store_in_to_temp;
    logic      store_temp_to_out;

    assign in_xfer = in_valid && in_ready;

    // ready next cycle unless the temp slot could fill up
    assign in_ready_early = out_ready || (!temp_valid && (!out_valid || !in_xfer));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready) begin
            if (out_ready || !out_valid) begin
                // straight to output
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park in temp
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain temp
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
            in_ready <= in_ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_desc <= in_desc;
        end else if (store_temp_to_out) begin
            out_desc <= temp_desc;
        end
        if (store_in_to_temp) begin
            temp_desc <= in_desc;
        end
    end

    // engine sees a stalled descriptor unchanged
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_desc))
        else $error("descriptor changed while stalled");

endmodule

`default_nettype wire

// ==== hw/desc_sts_demux.sv ====
// registered status router, port chosen by the upper tag bits
`timescale 1ns/100ps
`default_nettype none

module desc_sts_demux import desc_mux_pkg::*; #(
    parameter int ports = 4
) (
    input  wire              clk,
    input  wire              rst,

    input  dma_sts_t         in_sts,
    input  wire              in_valid,
    output client_sts_t      out_sts,
    output logic [ports-1:0] out_valid
);

    port_idx_t sts_idx;

    assign sts_idx = in_sts.tag[$bits(dma_tag_t)-1 -: port_idx_w];

    always_ff @(posedge clk) begin
        out_sts.len <= in_sts.len;
        // narrow back to the client tag
        out_sts.tag <= client_tag_t'(in_sts.tag);
        out_sts.error <= in_sts.error;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= '0;
        end else begin
            for (int n = 0; n < ports; n++) begin
                out_valid[n] <= in_valid && (sts_idx == n);
            end
        end
    end

    // engine must only return tags the mux handed out
    assert property (@(posedge clk) disable iff (rst) in_valid |-> int'(sts_idx) < ports)
        else $error("status tag names port %0d, only %0d ports", sts_idx, ports);

endmodule

`default_nettype wire
